/* design/dec_pkg.sv */
`default_nettype none

package dec_pkg;

  //////////////////////////////////////////////////////////////////////
  // Widths and sequencing constants
  //////////////////////////////////////////////////////////////////////
  localparam int XLEN             = 32;
  localparam int REG_ADDR_W       = 5;
  localparam int LOAD_WAIT_CYCLES = 3;                           // Wait steps after a load issue
  localparam int WAIT_CNT_W       = $clog2(LOAD_WAIT_CYCLES + 1);

  // funct3 codes of the two shift groups
  localparam logic [2:0] F3_SLL     = 3'b001;
  localparam logic [2:0] F3_SRL_SRA = 3'b101;

  //////////////////////////////////////////////////////////////////////
  // Encodings
  //////////////////////////////////////////////////////////////////////
  typedef enum logic [6:0] {
    OPC_LOAD     = 7'b0000011,
    OPC_MISC_MEM = 7'b0001111,                                   // FENCE
    OPC_OP_IMM   = 7'b0010011,
    OPC_AUIPC    = 7'b0010111,
    OPC_STORE    = 7'b0100011,
    OPC_OP       = 7'b0110011,
    OPC_LUI      = 7'b0110111,
    OPC_SYSTEM   = 7'b1110011
  } opcode_e;

  // Code is {funct7[5], funct3}
  typedef enum logic [3:0] {
    ALU_ADD  = 4'b0000,
    ALU_SUB  = 4'b1000,
    ALU_SLL  = 4'b0001,
    ALU_SLT  = 4'b0010,
    ALU_SLTU = 4'b0011,
    ALU_XOR  = 4'b0100,
    ALU_SRL  = 4'b0101,
    ALU_SRA  = 4'b1101,
    ALU_OR   = 4'b0110,
    ALU_AND  = 4'b0111
  } alu_op_e;

  typedef enum logic [2:0] {
    CLS_ALU,
    CLS_LOAD,
    CLS_STORE,
    CLS_NOP,
    CLS_ILLEGAL
  } instr_class_e;

  typedef enum logic [2:0] {
    SEQ_OK,
    SEQ_STALL,
    SEQ_MEM_ADDR,
    SEQ_STORE,
    SEQ_LOAD,
    SEQ_LOAD_WAIT
  } seq_state_e;

  //////////////////////////////////////////////////////////////////////
  // Bundles
  //////////////////////////////////////////////////////////////////////
  typedef struct packed {
    logic [REG_ADDR_W-1:0] rs1;
    logic                  rs1_used;
    logic [REG_ADDR_W-1:0] rs2;
    logic                  rs2_used;
    logic [REG_ADDR_W-1:0] rd;
    logic                  rd_write;                             // Never set for x0
  } src_use_t;

  typedef struct packed {
    alu_op_e               op;
    logic                  use_a;
    logic                  use_b;
    logic                  use_pc;
    logic                  use_imm;
    logic                  wb;
    logic [REG_ADDR_W-1:0] dest;
  } alu_ctrl_t;

  typedef struct packed {
    logic [REG_ADDR_W-1:0] addr_a;
    logic [REG_ADDR_W-1:0] addr_b;
  } rf_read_t;

  typedef struct packed {
    logic                  valid;
    logic                  store;
    logic [2:0]            size;                             // funct3 of the access
    logic [REG_ADDR_W-1:0] dest;
  } lsu_ctrl_t;

  typedef struct packed {
    alu_ctrl_t             alu;
    rf_read_t              rf;
    logic [XLEN-1:0]       imm;
    logic [XLEN-1:0]       pc;
    lsu_ctrl_t             lsu;
    logic                  illegal;
  } decode_out_t;

endpackage

`default_nettype wire

/* design/hazard_unit.sv */
`timescale 1ns/10ps
`default_nettype none

module hazard_unit import dec_pkg::*; (
  input  logic     clk_i,
  input  logic     rstn_i,
  input  src_use_t src_use_i,
  input  logic     instr_valid_i,
  input  logic     ready_i,
  output logic     stall_o
);

  logic [REG_ADDR_W-1:0] last_rd_q;                              // Zero means nothing pending
  logic                  stall_q;
  logic                  rs1_hit;
  logic                  rs2_hit;

  // Source compare against the pending destination
  assign rs1_hit = src_use_i.rs1_used && (src_use_i.rs1 != '0) &&
                   (src_use_i.rs1 == last_rd_q);
  assign rs2_hit = src_use_i.rs2_used && (src_use_i.rs2 != '0) &&
                   (src_use_i.rs2 == last_rd_q);

  // A single bubble is enough for the write to land
  assign stall_o = instr_valid_i && (rs1_hit || rs2_hit) && !stall_q;

  always_ff @(posedge clk_i) begin
    if (!rstn_i) begin
      last_rd_q <= '0;
      stall_q   <= 1'b0;
    end else begin
      stall_q <= stall_o;
      if (instr_valid_i && ready_i) begin
        // Accepted, remember its destination
        last_rd_q <= src_use_i.rd_write ? src_use_i.rd : '0;
      end else if (instr_valid_i) begin
        last_rd_q <= '0;                                         // Hazard window has passed
      end
    end
  end

endmodule

`default_nettype wire

/* design/imm_gen.sv */
`timescale 1ns/10ps
`default_nettype none

module imm_gen import dec_pkg::*; (
  input  logic [XLEN-1:0] instr_i,
  output logic [XLEN-1:0] imm_i_o,
  output logic [XLEN-1:0] imm_shift_o,
  output logic [XLEN-1:0] imm_s_o,
  output logic [XLEN-1:0] imm_u_o
);

  logic sign;

  assign sign = instr_i[31];

  //////////////////////////////////////////////////////////////////////
  // Immediate formats
  //////////////////////////////////////////////////////////////////////

  // I type, loads and OP-IMM
  assign imm_i_o = {{(XLEN-12){sign}}, instr_i[31:20]};

  // Shift amount sits in the rs2 field, upper bits carry funct7
  assign imm_shift_o = {{(XLEN-5){1'b0}}, instr_i[24:20]};

  // S type is split around the rd field
  assign imm_s_o = {
    {(XLEN-12){sign}},
    instr_i[31:25],                                              // imm[11:5]
    instr_i[11:7]                                                // imm[4:0]
  };

  // U type, LUI and AUIPC
  assign imm_u_o = {instr_i[31:12], 12'b0};

endmodule

`default_nettype wire

/* design/mem_seq_fsm.sv */
`timescale 1ns/10ps
`default_nettype none

module mem_seq_fsm import dec_pkg::*; (
  input  logic         clk_i,
  input  logic         rstn_i,
  input  logic         instr_valid_i,
  input  instr_class_e class_i,
  input  logic         stall_i,
  output seq_state_e   state_o,
  output logic         ready_o
);

  seq_state_e            state_q;                                // Step taken in the last cycle
  logic [WAIT_CNT_W-1:0] wait_cnt_q;                             // Wait steps already done
  logic                  wait_last;
  logic                  wait_busy;

  assign wait_last = (wait_cnt_q == WAIT_CNT_W'(LOAD_WAIT_CYCLES - 1));
  assign wait_busy = (state_q == SEQ_LOAD_WAIT) &&
                     (wait_cnt_q != WAIT_CNT_W'(LOAD_WAIT_CYCLES));

  //////////////////////////////////////////////////////////////////////
  // Current step from the previous one
  //////////////////////////////////////////////////////////////////////
  always_comb begin
    state_o = SEQ_OK;
    ready_o = 1'b0;
    if (rstn_i && instr_valid_i) begin                           // Fetch is held off in reset
      if (stall_i) begin
        state_o = SEQ_STALL;                                     // Hold fetch for one cycle
      end else begin
        case (class_i)
          CLS_STORE: begin
            if (state_q == SEQ_MEM_ADDR) begin
              state_o = SEQ_STORE;
              ready_o = 1'b1;
            end else begin
              state_o = SEQ_MEM_ADDR;
            end
          end
          CLS_LOAD: begin
            if (state_q == SEQ_MEM_ADDR) begin
              state_o = SEQ_LOAD;
            end else if (state_q == SEQ_LOAD) begin
              state_o = SEQ_LOAD_WAIT;                           // First wait step
            end else if (wait_busy) begin
              state_o = SEQ_LOAD_WAIT;
              ready_o = wait_last;
            end else begin
              state_o = SEQ_MEM_ADDR;                            // New load starts here
            end
          end
          default: begin
            ready_o = 1'b1;                                      // ALU, NOP and illegal
          end
        endcase
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Progress registers
  //////////////////////////////////////////////////////////////////////
  always_ff @(posedge clk_i) begin
    if (!rstn_i) begin
      state_q    <= SEQ_OK;
      wait_cnt_q <= '0;
    end else begin
      state_q <= state_o;
      if (state_o == SEQ_LOAD_WAIT) begin
        wait_cnt_q <= wait_cnt_q + 1'b1;
      end else begin
        wait_cnt_q <= '0;
      end
    end
  end

endmodule

`default_nettype wire

/* design/op_decode.sv */
`timescale 1ns/10ps
`default_nettype none

module op_decode import dec_pkg::*; (
  input  logic         clk_i,
  input  logic         rstn_i,
  input  logic [XLEN-1:0] instr_i,
  input  logic [XLEN-1:0] pc_i,
  input  logic         instr_valid_i,
  input  seq_state_e   state_i,
  input  logic [XLEN-1:0] imm_i_i,
  input  logic [XLEN-1:0] imm_shift_i,
  input  logic [XLEN-1:0] imm_s_i,
  input  logic [XLEN-1:0] imm_u_i,
  output instr_class_e class_o,
  output src_use_t     src_use_o,
  output decode_out_t  dec_out_o
);

  opcode_e               opcode;
  logic [2:0]            funct3;
  logic [REG_ADDR_W-1:0] rd;
  logic [REG_ADDR_W-1:0] rs1;
  logic [REG_ADDR_W-1:0] rs2;
  logic                  is_shift;
  decode_out_t           dec_d;

  // Instruction fields
  assign opcode   = opcode_e'(instr_i[6:0]);
  assign rd       = instr_i[11:7];
  assign funct3   = instr_i[14:12];
  assign rs1      = instr_i[19:15];
  assign rs2      = instr_i[24:20];
  assign is_shift = (funct3 == F3_SLL) || (funct3 == F3_SRL_SRA);

  //////////////////////////////////////////////////////////////////////
  // Class and register use
  //////////////////////////////////////////////////////////////////////
  always_comb begin
    class_o   = CLS_ILLEGAL;
    src_use_o = '0;
    src_use_o.rs1 = rs1;
    src_use_o.rs2 = rs2;
    src_use_o.rd  = rd;
    case (opcode)
      OPC_OP: begin
        class_o = CLS_ALU;
        src_use_o.rs1_used = 1'b1;
        src_use_o.rs2_used = 1'b1;
        src_use_o.rd_write = 1'b1;
      end
      OPC_OP_IMM, OPC_LOAD: begin
        class_o = (opcode == OPC_LOAD) ? CLS_LOAD : CLS_ALU;
        src_use_o.rs1_used = 1'b1;
        src_use_o.rd_write = 1'b1;
      end
      OPC_LUI, OPC_AUIPC: begin
        class_o = CLS_ALU;
        src_use_o.rd_write = 1'b1;
      end
      OPC_STORE: begin
        class_o = CLS_STORE;
        src_use_o.rs1_used = 1'b1;
        src_use_o.rs2_used = 1'b1;
      end
      OPC_MISC_MEM, OPC_SYSTEM: class_o = CLS_NOP;               // FENCE and SYSTEM retire as no-ops
      default: ;
    endcase
    src_use_o.rd_write = src_use_o.rd_write && (rd != '0);       // x0 is never written
  end

  //////////////////////////////////////////////////////////////////////
  // Controls for the current step
  //////////////////////////////////////////////////////////////////////
  always_comb begin
    dec_d = '0;                                                  // Bubble
    if (instr_valid_i) begin
      case (state_i)
        SEQ_OK: begin
          dec_d.pc      = pc_i;
          dec_d.illegal = (class_o == CLS_ILLEGAL);
          if (class_o == CLS_ALU) begin
            dec_d.alu.wb   = src_use_o.rd_write;
            dec_d.alu.dest = rd;
            case (opcode)
              OPC_OP: begin
                dec_d.alu.op    = alu_op_e'({instr_i[30], funct3});
                dec_d.alu.use_a = 1'b1;
                dec_d.alu.use_b = 1'b1;
                dec_d.rf.addr_a = rs1;
                dec_d.rf.addr_b = rs2;
              end
              OPC_OP_IMM: begin
                dec_d.alu.use_a   = 1'b1;
                dec_d.alu.use_imm = 1'b1;
                dec_d.rf.addr_a   = rs1;
                // Only shifts take bit 30 as the arithmetic select
                dec_d.alu.op = is_shift ? alu_op_e'({instr_i[30], funct3}) :
                                          alu_op_e'({1'b0, funct3});
                dec_d.imm    = is_shift ? imm_shift_i : imm_i_i;
              end
              OPC_LUI, OPC_AUIPC: begin
                dec_d.alu.op      = ALU_ADD;
                dec_d.alu.use_pc  = (opcode == OPC_AUIPC);
                dec_d.alu.use_imm = 1'b1;
                dec_d.imm         = imm_u_i;
              end
              default: ;
            endcase
          end
        end
        SEQ_MEM_ADDR: begin
          dec_d.pc          = pc_i;
          dec_d.alu.op      = ALU_ADD;                           // rs1 + offset
          dec_d.alu.use_a   = 1'b1;
          dec_d.alu.use_imm = 1'b1;
          dec_d.rf.addr_a   = rs1;
          dec_d.imm         = (class_o == CLS_STORE) ? imm_s_i : imm_i_i;
        end
        SEQ_STORE, SEQ_LOAD: begin
          dec_d.pc        = pc_i;
          dec_d.lsu.valid = 1'b1;
          dec_d.lsu.store = (state_i == SEQ_STORE);
          dec_d.lsu.size  = funct3;
          dec_d.lsu.dest  = (state_i == SEQ_LOAD) ? rd : '0;
          dec_d.rf.addr_b = (state_i == SEQ_STORE) ? rs2 : '0;  // Store data
        end
        default: ;                                               // STALL and LOAD_WAIT
      endcase
    end
  end

  // Output bundle, one edge behind the step
  always_ff @(posedge clk_i) begin
    dec_out_o <= dec_d;
    if (!rstn_i) begin
      dec_out_o.alu.wb    <= 1'b0;
      dec_out_o.lsu.valid <= 1'b0;
      dec_out_o.illegal   <= 1'b0;
    end
  end

endmodule

`default_nettype wire

/* design/rv32i_decoder.sv */
`timescale 1ns/10ps
`default_nettype none

module rv32i_decoder import dec_pkg::*; (
  input  logic            clk_i,
  input  logic            rstn_i,
  input  logic [XLEN-1:0] instr_i,
  input  logic [XLEN-1:0] pc_i,
  input  logic            instr_valid_i,
  output logic            ready_o,
  output decode_out_t     dec_out_o
);

  logic [XLEN-1:0] imm_i;
  logic [XLEN-1:0] imm_shift;
  logic [XLEN-1:0] imm_s;
  logic [XLEN-1:0] imm_u;
  instr_class_e    instr_class;
  src_use_t        src_use;
  logic            stall;
  seq_state_e      seq_state;

  //////////////////////////////////////////////////////////////////////
  // Decode chain
  //////////////////////////////////////////////////////////////////////
  imm_gen u_imm_gen (
    .instr_i     (instr_i),
    .imm_i_o     (imm_i),
    .imm_shift_o (imm_shift),
    .imm_s_o     (imm_s),
    .imm_u_o     (imm_u)
  );

  op_decode u_op_decode (
    .clk_i         (clk_i),
    .rstn_i        (rstn_i),
    .instr_i       (instr_i),
    .pc_i          (pc_i),
    .instr_valid_i (instr_valid_i),
    .state_i       (seq_state),
    .imm_i_i       (imm_i),
    .imm_shift_i   (imm_shift),
    .imm_s_i       (imm_s),
    .imm_u_i       (imm_u),
    .class_o       (instr_class),
    .src_use_o     (src_use),
    .dec_out_o     (dec_out_o)
  );

  hazard_unit u_hazard_unit (
    .clk_i         (clk_i),
    .rstn_i        (rstn_i),
    .src_use_i     (src_use),
    .instr_valid_i (instr_valid_i),
    .ready_i       (ready_o),                                    // Acceptance updates the pending rd
    .stall_o       (stall)
  );

  mem_seq_fsm u_mem_seq_fsm (
    .clk_i         (clk_i),
    .rstn_i        (rstn_i),
    .instr_valid_i (instr_valid_i),
    .class_i       (instr_class),
    .stall_i       (stall),
    .state_o       (seq_state),
    .ready_o       (ready_o)
  );

endmodule

`default_nettype wire

/* run.sh */
#!/usr/bin/env bash
# Build and run the decoder testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_decoder -f tb.f -o sim_decoder

./obj_dir/sim_decoder

/* tb.f */
design/dec_pkg.sv
design/imm_gen.sv
design/hazard_unit.sv
design/mem_seq_fsm.sv
design/op_decode.sv
design/rv32i_decoder.sv
tests/decoder_checker.sv
tests/tb_decoder.sv

/* tests/decoder_checker.sv */
`timescale 1ns/10ps
`default_nettype none

module decoder_checker import dec_pkg::*; (
  input logic        clk_i,
  input logic        rstn_i,
  input logic        ready_i,
  input decode_out_t dec_out_i
);

  //////////////////////////////////////////////////////////////////////
  // Output bundle rules
  //////////////////////////////////////////////////////////////////////
  a_lsu_wb_excl: assert property (@(posedge clk_i) disable iff (!rstn_i)
    !(dec_out_i.lsu.valid && dec_out_i.alu.wb))
    else $error("LSU valid and writeback set together");

  a_illegal_no_wb: assert property (@(posedge clk_i) disable iff (!rstn_i)
    dec_out_i.illegal |-> !dec_out_i.alu.wb)
    else $error("Illegal bundle carries writeback");

  a_no_x0_wb: assert property (@(posedge clk_i) disable iff (!rstn_i)
    dec_out_i.alu.wb |-> (dec_out_i.alu.dest != '0))
    else $error("Writeback targets x0");

  // Fetch handshake held off while in reset
  a_ready_reset: assert property (@(posedge clk_i) !rstn_i |-> !ready_i)
    else $error("Ready high during reset");

endmodule

bind rv32i_decoder decoder_checker u_decoder_checker (
  .clk_i     (clk_i),
  .rstn_i    (rstn_i),
  .ready_i   (ready_o),
  .dec_out_i (dec_out_o)
);

`default_nettype wire

/* tests/tb_decoder.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_decoder import dec_pkg::*; ;

  localparam int N_RAND   = 6;

  typedef struct packed {
    logic [31:0] instr;
    logic [31:0] pc;
    logic [3:0]  cycles;                                         // Without any stall
    logic        mem;
    logic        wb;
    logic [4:0]  dest;
    logic [3:0]  op;
    logic [31:0] imm;                                            // Address offset for memory rows
    logic        use_pc;
    logic        lsu_valid;
    logic        lsu_store;
    logic [2:0]  size;
    logic [4:0]  lsu_dest;
    logic        illegal;
  } row_t;

  logic        clk;
  logic        rstn;
  logic [31:0] instr;
  logic [31:0] pc;
  logic        valid;
  logic        ready;
  decode_out_t dec_out;
  row_t        rows[$];
  logic [31:0] seed;
  logic [4:0]  prev_rd;                                          // Pending destination model
  logic        lsu_seen;
  lsu_ctrl_t   lsu_cap;
  logic [31:0] addr_imm;

  rv32i_decoder u_rv32i_decoder (
    .clk_i         (clk),
    .rstn_i        (rstn),
    .instr_i       (instr),
    .pc_i          (pc),
    .instr_valid_i (valid),
    .ready_o       (ready),
    .dec_out_o     (dec_out)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  //////////////////////////////////////////////////////////////////////
  // Helpers
  //////////////////////////////////////////////////////////////////////
  function automatic logic [31:0] lcg_next();
    seed = seed * 32'd1103515245 + 32'd12345;
    return seed;
  endfunction

  function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                        input logic [4:0] rs1, input logic [2:0] f3,
                                        input logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, 7'b0110011};
  endfunction

  function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                        input logic [2:0] f3, input logic [4:0] rd,
                                        input logic [6:0] opc);
    return {imm, rs1, f3, rd, opc};
  endfunction

  function automatic row_t make_row(input logic [31:0] i, input logic [3:0] cyc,
                                    input logic m, input logic w, input logic [4:0] d,
                                    input logic [3:0] o, input logic [31:0] im,
                                    input logic up, input logic lv, input logic ls,
                                    input logic [2:0] sz, input logic [4:0] ld,
                                    input logic ill);
    row_t r;
    r = '0;
    r.instr = i;
    r.pc = 32'h100 + 32'(rows.size() * 4);
    r.cycles = cyc;
    r.mem = m;
    r.wb = w;
    r.dest = d;
    r.op = o;
    r.imm = im;
    r.use_pc = up;
    r.lsu_valid = lv;
    r.lsu_store = ls;
    r.size = sz;
    r.lsu_dest = ld;
    r.illegal = ill;
    return r;
  endfunction

  // Random OP-IMM row, expected fields from the ISA encoding rules
  function automatic row_t random_opimm();
    logic [31:0] r;
    logic [11:0] imm;
    logic [2:0]  f3;
    logic [3:0]  op;
    logic [31:0] imm_exp;
    r   = lcg_next();
    f3  = r[14:12];
    imm = r[31:20];
    if (f3 == 3'b001 || f3 == 3'b101) begin
      imm[11:5] = (f3 == 3'b101 && r[30]) ? 7'h20 : 7'h00;
      op        = {imm[10], f3};
      imm_exp   = {27'b0, imm[4:0]};
    end else begin
      op        = {1'b0, f3};
      imm_exp   = {{20{imm[11]}}, imm};
    end
    return make_row(enc_i(imm, r[9:5], f3, r[4:0], 7'b0010011), 4'd1, 1'b0,
                    r[4:0] != 5'd0, r[4:0], op, imm_exp, 1'b0, 1'b0, 1'b0, 3'd0,
                    5'd0, 1'b0);
  endfunction

  // Read-after-write against the previous writing destination
  function automatic logic raw_hazard(input logic [31:0] i);
    logic [6:0] opc;
    logic       use1;
    logic       use2;
    opc  = i[6:0];
    use1 = opc inside {7'b0110011, 7'b0010011, 7'b0000011, 7'b0100011};
    use2 = opc inside {7'b0110011, 7'b0100011};
    return (prev_rd != 5'd0) && ((use1 && i[19:15] == prev_rd) ||
                                 (use2 && i[24:20] == prev_rd));
  endfunction

  function automatic logic [4:0] written_rd(input logic [31:0] i);
    logic [6:0] opc;
    opc = i[6:0];
    if (opc inside {7'b0110011, 7'b0010011, 7'b0000011, 7'b0110111, 7'b0010111})
      return i[11:7];
    return 5'd0;
  endfunction

  task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("Fail %s got %h expected %h", name, got, exp);
      $display("Simulation failed");
      $fatal(1);
    end
  endtask

  task automatic observe(input row_t r);
    if (dec_out.lsu.valid) begin
      lsu_seen = 1'b1;
      lsu_cap  = dec_out.lsu;
    end
    if (r.mem && dec_out.alu.use_imm) addr_imm = dec_out.imm;
  endtask

  task automatic apply_row(input row_t r);
    int   n;
    logic done;
    logic [3:0] exp_cyc;
    exp_cyc  = r.cycles + 4'(raw_hazard(r.instr));
    lsu_seen = 1'b0;
    lsu_cap  = '0;
    addr_imm = '0;
    n        = 0;
    done     = 1'b0;
    @(posedge clk);
    instr <= r.instr;
    pc    <= r.pc;
    valid <= 1'b1;
    while (!done) begin
      @(negedge clk);
      n++;
      observe(r);
      if (ready) done = 1'b1;
      else @(posedge clk);
    end
    @(posedge clk);                                              // Accepting edge
    valid <= 1'b0;
    @(negedge clk);
    observe(r);
    check("ready_cycles", 32'(n), 32'(exp_cyc));
    check("alu.wb", 32'(dec_out.alu.wb), 32'(r.wb));
    check("alu.dest", 32'(dec_out.alu.dest), 32'(r.dest));
    check("alu.op", 32'(dec_out.alu.op), 32'(r.op));
    check("alu.use_pc", 32'(dec_out.alu.use_pc), 32'(r.use_pc));
    check("illegal", 32'(dec_out.illegal), 32'(r.illegal));
    check("imm", r.mem ? addr_imm : dec_out.imm, r.imm);
    check("lsu.valid", 32'(lsu_seen), 32'(r.lsu_valid));
    check("lsu.store", 32'(lsu_cap.store), 32'(r.lsu_store));
    check("lsu.size", 32'(lsu_cap.size), 32'(r.size));
    check("lsu.dest", 32'(lsu_cap.dest), 32'(r.lsu_dest));
    prev_rd = written_rd(r.instr);
  endtask

  //////////////////////////////////////////////////////////////////////
  // Stimulus table and run
  //////////////////////////////////////////////////////////////////////
  initial begin
    rstn    = 1'b0;
    instr   = 32'h00000013;                                      // NOP offered during reset
    pc      = '0;
    valid   = 1'b1;
    seed    = 32'd65190;
    prev_rd = 5'd0;
    rows.push_back(make_row(enc_i(12'd5, 5'd0, 3'b000, 5'd1, 7'b0010011), 1, 0, 1, 1,
                            4'h0, 32'd5, 0, 0, 0, 0, 0, 0));
    rows.push_back(make_row(enc_r(7'h00, 5'd1, 5'd1, 3'b000, 5'd2), 1, 0, 1, 2,
                            4'h0, 32'd0, 0, 0, 0, 0, 0, 0));
    rows.push_back(make_row(enc_r(7'h20, 5'd0, 5'd2, 3'b000, 5'd3), 1, 0, 1, 3,
                            4'h8, 32'd0, 0, 0, 0, 0, 0, 0));
    rows.push_back(make_row(enc_i(12'h407, 5'd3, 3'b101, 5'd4, 7'b0010011), 1, 0, 1, 4,
                            4'hd, 32'd7, 0, 0, 0, 0, 0, 0));
    rows.push_back(make_row(enc_i(12'hfff, 5'd0, 3'b100, 5'd5, 7'b0010011), 1, 0, 1, 5,
                            4'h4, 32'hffffffff, 0, 0, 0, 0, 0, 0));
    rows.push_back(make_row(enc_i(12'd1, 5'd5, 3'b000, 5'd0, 7'b0010011), 1, 0, 0, 0,
                            4'h0, 32'd1, 0, 0, 0, 0, 0, 0));
    rows.push_back(make_row({20'h12345, 5'd6, 7'b0110111}, 1, 0, 1, 6,
                            4'h0, 32'h12345000, 0, 0, 0, 0, 0, 0));
    rows.push_back(make_row({20'hfffff, 5'd7, 7'b0010111}, 1, 0, 1, 7,
                            4'h0, 32'hfffff000, 1, 0, 0, 0, 0, 0));
    // SW x7, -4(x1)
    rows.push_back(make_row({7'h7f, 5'd7, 5'd1, 3'b010, 5'h1c, 7'b0100011}, 2, 1, 0, 0,
                            4'h0, 32'hfffffffc, 0, 1, 1, 3'b010, 0, 0));
    rows.push_back(make_row(enc_i(12'd16, 5'd2, 3'b010, 5'd8, 7'b0000011), 5, 1, 0, 0,
                            4'h0, 32'd16, 0, 1, 0, 3'b010, 8, 0));
    rows.push_back(make_row(enc_r(7'h00, 5'd0, 5'd8, 3'b000, 5'd9), 1, 0, 1, 9,
                            4'h0, 32'd0, 0, 0, 0, 0, 0, 0));
    rows.push_back(make_row(32'h0000007f, 1, 0, 0, 0, 4'h0, 32'd0, 0, 0, 0, 0, 0, 1));
    rows.push_back(make_row(32'h0000000f, 1, 0, 0, 0, 4'h0, 32'd0, 0, 0, 0, 0, 0, 0));
    rows.push_back(make_row(32'h00000073, 1, 0, 0, 0, 4'h0, 32'd0, 0, 0, 0, 0, 0, 0));
    for (int k = 0; k < N_RAND; k++) rows.push_back(random_opimm());
    repeat (3) @(posedge clk);
    rstn  <= 1'b1;
    valid <= 1'b0;
    foreach (rows[k]) apply_row(rows[k]);
    $display("Simulation passed");
    $finish;
  end

  // Watchdog, at most eight cycles per row plus reset
  initial begin
    @(posedge clk);                                              // Table is filled by now
    repeat (rows.size() * 8 + 10) @(posedge clk);
    $display("Timeout waiting for ready from the DUT");
    $display("Simulation failed");
    $fatal(1);
  end

endmodule

`default_nettype wire
